//--- build.f
source/mipsPkg.sv
source/pipelineReg.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/mipsPipeline.sv
sim/mipsPipelineTb.sv

//--- run.sh
#!/bin/sh
# build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module mipsPipelineTb -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/VmipsPipelineTb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the log decides pass or fail
if grep -q "Regression passed" "$log"; then
	exit 0
fi
exit 1

//--- sim/mipsPipelineTb.sv
// MIPS pipeline testbench
`timescale 1ns/1ps
`default_nettype none

module mipsPipelineTb import mipsPkg::*; ();

	localparam int numSlots = 20;
	localparam int resetCycles = 3;
	// a slot retires 4 cycles after its fetch
	localparam int drainCycles = 4;
	localparam int timeoutCycles = numSlots + drainCycles + resetCycles + 8;

	// one program slot and the write it should retire
	typedef struct packed {
		wordT instr;
		wbEventT expected;
	} slotT;

	logic clk;
	logic reset;
	wordT pc;
	wordT instruction;
	wbEventT writeback;

	slotT slots [numSlots];
	string slotNames [numSlots];
	int checks;
	int pcErrors;
	int wbErrors;
	int cycleCount;

	mipsPipeline u_mipsPipeline (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.instruction(instruction),
		.writeback(writeback)
	);

	// 4 ns clock
	always #2 clk = ~clk;

	// instruction memory model, nop past the end of the program
	always_comb begin
		instruction = '0;
		for (int i = 0; i < numSlots; i++) begin
			if (pc == wordT'(i * 4)) begin
				instruction = slots[i].instr;
			end
		end
	end

	// run limit from program length plus fill and reset
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("timeout after %0d cycles, the run never reached its end", cycleCount);
			$display("Regression failed");
			$finish;
		end
	end

	function automatic wordT encodeR(regAddrT rs, regAddrT rt, regAddrT rd, functT funct);
		return {opRtype, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic wordT encodeI(logic [5:0] op, regAddrT rs, regAddrT rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic loadSlot(input int idx, input string name, input wordT instr,
		input logic valid, input regAddrT regNum, input wordT data);
		slotNames[idx] = name;
		slots[idx].instr = instr;
		slots[idx].expected = '{valid: valid, regNum: regNum, data: data};
	endtask

	// consumers sit at least three slots after their producer
	task automatic loadProgram();
		// immediates, positive and negative
		loadSlot(0, "addi r1 5", encodeI(opAddi, 5'd0, 5'd1, 16'd5), 1'b1, 5'd1, 32'h5);
		loadSlot(1, "addi r2 -3", encodeI(opAddi, 5'd0, 5'd2, 16'hfffd), 1'b1, 5'd2, 32'hfffffffd);
		loadSlot(2, "addi r3 12", encodeI(opAddi, 5'd0, 5'd3, 16'd12), 1'b1, 5'd3, 32'hc);
		// exactly three after r1 is written, so write-through
		loadSlot(3, "addi r5 r1-7", encodeI(opAddi, 5'd1, 5'd5, 16'hfff9), 1'b1, 5'd5, 32'hfffffffe);
		// r-type arithmetic
		loadSlot(4, "add r4", encodeR(5'd1, 5'd2, 5'd4, fnAdd), 1'b1, 5'd4, 32'h2);
		loadSlot(5, "sub r6", encodeR(5'd3, 5'd1, 5'd6, fnSub), 1'b1, 5'd6, 32'h7);
		loadSlot(6, "and r7", encodeR(5'd3, 5'd1, 5'd7, fnAnd), 1'b1, 5'd7, 32'h4);
		loadSlot(7, "or r8", encodeR(5'd3, 5'd1, 5'd8, fnOr), 1'b1, 5'd8, 32'hd);
		// -3 < 5 signed
		loadSlot(8, "slt r9 neg", encodeR(5'd2, 5'd1, 5'd9, fnSlt), 1'b1, 5'd9, 32'h1);
		loadSlot(9, "slt r10 pos", encodeR(5'd1, 5'd2, 5'd10, fnSlt), 1'b1, 5'd10, 32'h0);
		// stores to words 2 and 4, no strobe
		loadSlot(10, "sw r3 8(r0)", encodeI(opSw, 5'd0, 5'd3, 16'd8), 1'b0, 5'd0, 32'h0);
		loadSlot(11, "sw r2 4(r3)", encodeI(opSw, 5'd3, 5'd2, 16'd4), 1'b0, 5'd0, 32'h0);
		// unknown opcode decodes as a nop
		loadSlot(12, "bad opcode", encodeI(6'h3f, 5'd1, 5'd11, 16'h1234), 1'b0, 5'd0, 32'h0);
		// write to r0 is dropped
		loadSlot(13, "addi r0", encodeI(opAddi, 5'd1, 5'd0, 16'd9), 1'b0, 5'd0, 32'h0);
		loadSlot(14, "lw r11 8(r0)", encodeI(opLw, 5'd0, 5'd11, 16'd8), 1'b1, 5'd11, 32'hc);
		loadSlot(15, "lw r12 4(r3)", encodeI(opLw, 5'd3, 5'd12, 16'd4), 1'b1, 5'd12, 32'hfffffffd);
		// word 10 never written
		loadSlot(16, "lw r13 40(r0)", encodeI(opLw, 5'd0, 5'd13, 16'd40), 1'b1, 5'd13, 32'h0);
		// r0 still zero after the dropped write
		loadSlot(17, "add r14 r0", encodeR(5'd0, 5'd0, 5'd14, fnAdd), 1'b1, 5'd14, 32'h0);
		// r12 three slots back, both loaded words summed
		loadSlot(18, "add r15 loads", encodeR(5'd11, 5'd12, 5'd15, fnAdd), 1'b1, 5'd15, 32'h9);
		loadSlot(19, "nop", 32'h0, 1'b0, 5'd0, 32'h0);
	endtask

	task automatic checkPc(input string name, input wordT expected, input wordT actual);
		checks++;
		if (actual !== expected) begin
			pcErrors++;
			$display("CHECK FAILED %s: expected %h actual %h", name, expected, actual);
		end
	endtask

	// register and data only matter when a write is expected
	task automatic checkWriteback(input string name, input wbEventT expected, input wbEventT actual);
		logic bad;
		bad = expected.valid ? (actual !== expected) : (actual.valid !== 1'b0);
		checks++;
		if (bad) begin
			wbErrors++;
			$display("CHECK FAILED %s: expected valid %b reg %0d data %h actual valid %b reg %0d data %h",
				name, expected.valid, expected.regNum, expected.data,
				actual.valid, actual.regNum, actual.data);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		checks = 0;
		pcErrors = 0;
		wbErrors = 0;
		cycleCount = 0;
		loadProgram();
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;
		// sample mid-cycle, cycle c fetches slot c and retires slot c-4
		for (int c = 0; c < numSlots + drainCycles; c++) begin
			@(negedge clk);
			checkPc($sformatf("pc cycle %0d", c), wordT'(c * 4), pc);
			if (c < drainCycles) begin
				checkWriteback($sformatf("pipeline fill %0d", c), '0, writeback);
			end else begin
				checkWriteback(slotNames[c - drainCycles], slots[c - drainCycles].expected,
					writeback);
			end
		end
		$display("checks %0d, pc errors %0d, writeback errors %0d", checks, pcErrors, wbErrors);
		if (pcErrors + wbErrors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- source/decodeStage.sv
// Decode stage with register file
`timescale 1ns/1ps
`default_nettype none

module decodeStage import mipsPkg::*; (
	input  wire logic clk,
	input  wire logic reset,
	input  ifIdT ifId,
	input  memWbT memWb,
	output idExT idEx,
	output wbEventT writeback
);

	logic [xlen-1:0] regFile [2**regAddrBits];
	opcodeT opcode;
	regAddrT rs;
	regAddrT rt;
	ctrlT ctrl;
	wordT wbData;
	logic wbWrite;

	assign opcode = opcodeT'(ifId.instruction[31:26]);
	assign rs = ifId.instruction[25:21];
	assign rt = ifId.instruction[20:16];

	// main control unit
	always_comb begin
		ctrl = '0;
		case (opcode)
			opRtype: begin
				ctrl.regDst = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluOpRtype;
			end
			opLw: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memtoReg = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
			end
			opSw: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			opAddi: begin
				// same add path as lw and sw with the result to rt
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			// unknown opcodes fall through as a nop
			default: ctrl = '0;
		endcase
	end

	// writeback mux picks the load word on memtoReg
	assign wbData = memWb.memtoReg ? memWb.loadData : memWb.aluResult;
	// writes to $zero are dropped here
	assign wbWrite = memWb.regWrite && (memWb.destReg != '0);

	// register file, written at the end of the WB cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**regAddrBits; i++) begin
				regFile[i] <= '0;
			end
		end else if (wbWrite) begin
			regFile[memWb.destReg] <= wbData;
		end
	end

	// read ports bypass the same-cycle write
	always_comb begin
		idEx.ctrl = ctrl;
		idEx.pcPlus4 = ifId.pcPlus4;
		idEx.readData1 = (wbWrite && memWb.destReg == rs) ? wbData : regFile[rs];
		idEx.readData2 = (wbWrite && memWb.destReg == rt) ? wbData : regFile[rt];
		// sign-extended 16-bit immediate
		idEx.signExt = {{16{ifId.instruction[15]}}, ifId.instruction[15:0]};
		idEx.rt = rt;
		idEx.rd = ifId.instruction[15:11];
	end

	assign writeback.valid = wbWrite;
	assign writeback.regNum = memWb.destReg;
	assign writeback.data = wbData;

	// load data only arrives here for an instruction that writes a register
	loadWrites: assert property (@(posedge clk) disable iff (reset)
		memWb.memtoReg |-> memWb.regWrite);

endmodule

`default_nettype wire

//--- source/executeStage.sv
// Execute stage
`timescale 1ns/1ps
`default_nettype none

module executeStage import mipsPkg::*; (
	input  idExT idEx,
	output exMemT exMem
);

	functT funct;
	aluCtrlT aluCtrl;
	wordT operandA;
	wordT operandB;
	wordT aluResult;

	// function code sits in the low bits of the immediate
	assign funct = functT'(idEx.signExt[5:0]);

	// ALU control
	always_comb begin
		aluCtrl = aluAdd;
		if (idEx.ctrl.aluOp == aluOpRtype) begin
			case (funct)
				fnAdd: aluCtrl = aluAdd;
				fnSub: aluCtrl = aluSub;
				fnAnd: aluCtrl = aluAnd;
				fnOr: aluCtrl = aluOr;
				fnSlt: aluCtrl = aluSlt;
				default: aluCtrl = aluAdd;
			endcase
		end
	end

	assign operandA = idEx.readData1;
	// ALUSrc mux
	assign operandB = idEx.ctrl.aluSrc ? idEx.signExt : idEx.readData2;

	// main ALU
	always_comb begin
		case (aluCtrl)
			aluSub: aluResult = operandA - operandB;
			aluAnd: aluResult = operandA & operandB;
			aluOr: aluResult = operandA | operandB;
			// signed compare
			aluSlt: aluResult = {{(xlen-1){1'b0}}, $signed(operandA) < $signed(operandB)};
			default: aluResult = operandA + operandB;
		endcase
	end

	assign exMem.ctrl = idEx.ctrl;
	assign exMem.aluResult = aluResult;
	// rt value goes on as store data
	assign exMem.storeData = idEx.readData2;
	// RegDst mux, rd for r-type, rt otherwise
	assign exMem.destReg = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

endmodule

`default_nettype wire

//--- source/fetchStage.sv
// Instruction fetch stage
`timescale 1ns/1ps
`default_nettype none

module fetchStage import mipsPkg::*; (
	input  wire logic clk,
	input  wire logic reset,
	output wordT pc,
	input  wordT instruction,
	output ifIdT ifId
);

	wordT pcPlus4;

	// without branches the next pc is always pc + 4
	assign pcPlus4 = pc + wordT'(4);

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else begin
			pc <= pcPlus4;
		end
	end

	// instruction port answers in the same cycle
	assign ifId.pcPlus4 = pcPlus4;
	assign ifId.instruction = instruction;

	// the instruction port must return a defined word
	instrKnown: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(instruction));

endmodule

`default_nettype wire

//--- source/memoryStage.sv
// Data memory stage
`timescale 1ns/1ps
`default_nettype none

module memoryStage import mipsPkg::*; (
	input  wire logic clk,
	input  exMemT exMem,
	output memWbT memWb
);

	logic [xlen-1:0] dmem [dmemWords];
	logic [dmemAddrBits-1:0] wordIdx;

	// word address, byte offset ignored
	assign wordIdx = exMem.aluResult[dmemAddrBits+1:2];

	// memory starts out all zero
	initial begin
		for (int i = 0; i < dmemWords; i++) begin
			dmem[i] = '0;
		end
	end

	// store lands at the edge ending the MEM cycle
	always_ff @(posedge clk) begin
		if (exMem.ctrl.memWrite) begin
			dmem[wordIdx] <= exMem.storeData;
		end
	end

	assign memWb.regWrite = exMem.ctrl.regWrite;
	assign memWb.memtoReg = exMem.ctrl.memtoReg;
	// combinational read, zero when not loading
	assign memWb.loadData = exMem.ctrl.memRead ? dmem[wordIdx] : '0;
	assign memWb.aluResult = exMem.aluResult;
	assign memWb.destReg = exMem.destReg;

	// decode never issues a load and store together
	memRdWrExclusive: assert property (@(posedge clk)
		!(exMem.ctrl.memRead && exMem.ctrl.memWrite));

endmodule

`default_nettype wire

//--- source/mipsPipeline.sv
// Five-stage MIPS pipeline top
`timescale 1ns/1ps
`default_nettype none

module mipsPipeline import mipsPkg::*; (
	input  wire logic clk,
	input  wire logic reset,
	output wordT pc,
	input  wordT instruction,
	output wbEventT writeback
);

	// stage outputs, before each boundary
	ifIdT ifIdNext;
	idExT idExNext;
	exMemT exMemNext;
	memWbT memWbNext;
	// boundary register outputs
	ifIdT ifId;
	idExT idEx;
	exMemT exMem;
	memWbT memWb;

	fetchStage u_fetchStage (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.instruction(instruction),
		.ifId(ifIdNext)
	);

	pipelineReg #(.payloadT(ifIdT)) ifIdReg (.clk(clk), .reset(reset), .d(ifIdNext), .q(ifId));

	// decode also owns writeback via memWb
	decodeStage u_decodeStage (
		.clk(clk),
		.reset(reset),
		.ifId(ifId),
		.memWb(memWb),
		.idEx(idExNext),
		.writeback(writeback)
	);

	pipelineReg #(.payloadT(idExT)) idExReg (.clk(clk), .reset(reset), .d(idExNext), .q(idEx));

	executeStage u_executeStage (
		.idEx(idEx),
		.exMem(exMemNext)
	);

	pipelineReg #(.payloadT(exMemT)) exMemReg (.clk(clk), .reset(reset), .d(exMemNext), .q(exMem));

	memoryStage u_memoryStage (
		.clk(clk),
		.exMem(exMem),
		.memWb(memWbNext)
	);

	pipelineReg #(.payloadT(memWbT)) memWbReg (.clk(clk), .reset(reset), .d(memWbNext), .q(memWb));

endmodule

`default_nettype wire

//--- source/mipsPkg.sv
// MIPS pipeline shared types
`default_nettype none

package mipsPkg;

	// datapath and register index widths
	localparam int xlen = 32;
	localparam int regAddrBits = 5;
	// data memory depth in words, indexed from aluResult bit 2 up
	localparam int dmemWords = 64;
	localparam int dmemAddrBits = $clog2(dmemWords);

	typedef logic [xlen-1:0] wordT;
	typedef logic [regAddrBits-1:0] regAddrT;

	// instruction bits 31:26
	typedef enum logic [5:0] {
		opRtype = 6'd0,
		opAddi  = 6'd8,
		opLw    = 6'd35,
		opSw    = 6'd43
	} opcodeT;

	// r-type function field, bits 5:0
	typedef enum logic [5:0] {
		fnAdd = 6'd32,
		fnSub = 6'd34,
		fnAnd = 6'd36,
		fnOr  = 6'd37,
		fnSlt = 6'd42
	} functT;

	// aluOp class from main control
	typedef enum logic [1:0] {
		aluOpMem   = 2'b00,
		aluOpRtype = 2'b10
	} aluOpT;

	// classic MIPS ALU control encoding
	typedef enum logic [3:0] {
		aluAnd = 4'b0000,
		aluOr  = 4'b0001,
		aluAdd = 4'b0010,
		aluSub = 4'b0110,
		aluSlt = 4'b0111
	} aluCtrlT;

	// all zero is a nop, nothing written anywhere
	typedef struct packed {
		logic regWrite;
		logic memtoReg;
		logic memRead;
		logic memWrite;
		logic aluSrc;
		logic regDst;
		aluOpT aluOp;
	} ctrlT;

	typedef struct packed {
		wordT pcPlus4;
		wordT instruction;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		wordT pcPlus4;
		wordT readData1;
		wordT readData2;
		wordT signExt;
		regAddrT rt;
		regAddrT rd;
	} idExT;

	typedef struct packed {
		ctrlT ctrl;
		wordT aluResult;
		wordT storeData;
		regAddrT destReg;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		logic memtoReg;
		wordT loadData;
		wordT aluResult;
		regAddrT destReg;
	} memWbT;

	// one retired register write
	typedef struct packed {
		logic valid;
		regAddrT regNum;
		wordT data;
	} wbEventT;

endpackage

`default_nettype wire

//--- source/pipelineReg.sv
// Stage boundary register
`timescale 1ns/1ps
`default_nettype none

module pipelineReg #(
	parameter type payloadT = logic
) (
	input  wire logic clk,
	input  wire logic reset,
	input  payloadT d,
	output payloadT q
);

	// zero payload means every control bit low, so reset leaves a nop
	always_ff @(posedge clk) begin
		if (reset) begin
			q <= '0;
		end else begin
			q <= d;
		end
	end

endmodule

`default_nettype wire
